/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_game -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_game)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

/* sim.f */
src/popeye_cfg_pkg.sv
src/popeye_video_pkg.sv
src/jtpopeye_cen.sv
src/jtpopeye_prom_we.sv
src/jtpopeye_bram.sv
src/jtpopeye_vtiming.sv
src/jtpopeye_palette.sv
src/jtpopeye_game.sv
tests/tb_game.sv

/* src/jtpopeye_bram.sv */
`timescale 1ns/1ps

module jtpopeye_bram(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     game_reset,
    input  logic                                     downloading,
    input  logic [popeye_cfg_pkg::main_rom_aw-1:0]   prog_addr,
    input  logic [popeye_cfg_pkg::data_w-1:0]        prog_data,
    input  logic [popeye_cfg_pkg::bank_n-1:0]        prom_we,
    input  logic                                     main_cs,
    input  logic [popeye_cfg_pkg::main_rom_aw-1:0]   main_addr,
    output logic [popeye_cfg_pkg::data_w-1:0]        main_data,
    output logic                                     main_ok,
    output logic                                     ready
);

import popeye_cfg_pkg::*;

logic [data_w-1:0]             mem [bank_n][2**bank_aw];
logic [data_w-1:0]             bank_q [bank_n];
logic [main_rom_aw-bank_aw-1:0] sel_q;
logic                          got_data;
logic                          ready_q;
logic                          ok_q;

// Every bank reads each cycle, the bank select follows one cycle behind
always_ff @(posedge clk) begin
    for (int b = 0; b < bank_n; b++) begin
        if (prom_we[b]) mem[b][prog_addr[bank_aw-1:0]] <= prog_data;
        if (main_cs) bank_q[b] <= mem[b][main_addr[bank_aw-1:0]];
    end
    if (main_cs) sel_q <= main_addr[main_rom_aw-1:bank_aw];
end

assign main_data = bank_q[sel_q];

always_ff @(posedge clk) begin
    if (reset) begin
        got_data <= 1'b0;
        ready_q  <= 1'b0;
        ok_q     <= 1'b0;
    end else begin
        if (|prom_we) got_data <= 1'b1;
        ready_q <= got_data & ~downloading;
        ok_q    <= main_cs & ~game_reset;
    end
end

assign ready   = ready_q & ~downloading;  // Drops as soon as a new download starts
assign main_ok = ok_q & ~game_reset;      // game_reset already covers ~ready

a_no_ok_in_download: assert property (
    @(posedge clk) disable iff (reset)
    downloading |-> !main_ok
) else $error("main_ok high during ROM download");

endmodule

/* src/jtpopeye_cen.sv */
`timescale 1ns/1ps

module jtpopeye_cen(
    input  logic clk,       // 20 MHz
    input  logic reset,
    output logic pxl_cen,   // 5 MHz
    output logic pxl2_cen,  // 10 MHz
    output logic sample     // 1.25 MHz
);

// Low two bits give the pixel phases, all four the sound phase
logic [3:0] cnt;

always_ff @(posedge clk) begin
    if (reset) begin
        cnt <= 4'd0;
    end else begin
        cnt <= cnt + 4'd1;
    end
end

// Each enable fires on the last phase of its period,
// so none is active while cnt is still zero after reset
assign pxl2_cen = cnt[0];
assign pxl_cen  = &cnt[1:0];
assign sample   = &cnt;     // Lines up with a pixel enable

endmodule

/* src/jtpopeye_game.sv */
`timescale 1ns/1ps

module jtpopeye_game(
    input  logic                                     clk,        // 20 MHz
    input  logic                                     reset,
    // ROM download
    input  logic                                     downloading,
    input  logic [popeye_cfg_pkg::dl_addr_w-1:0]     ioctl_addr,
    input  logic [popeye_cfg_pkg::data_w-1:0]        ioctl_data,
    input  logic                                     ioctl_wr,
    // CPU side of the main ROM
    input  logic                                     main_cs,
    input  logic [popeye_cfg_pkg::main_rom_aw-1:0]   main_addr,
    // Colour index from the tile side
    input  logic [popeye_video_pkg::pal_aw-1:0]      pal_idx,
    output logic                                     pxl_cen,
    output logic                                     pxl2_cen,
    output logic                                     sample,
    output logic [popeye_cfg_pkg::dl_addr_w-1:0]     prog_addr,
    output logic [popeye_cfg_pkg::data_w-1:0]        prog_data,
    output logic                                     prog_we,
    output logic                                     encrypted,
    output logic [popeye_cfg_pkg::data_w-1:0]        main_data,
    output logic                                     main_ok,
    output logic                                     HB,
    output logic                                     VB,
    output logic                                     HS,
    output logic                                     VS,
    output logic [popeye_video_pkg::red_w-1:0]       red,
    output logic [popeye_video_pkg::green_w-1:0]     green,
    output logic [popeye_video_pkg::blue_w-1:0]      blue
);

import popeye_cfg_pkg::*;
import popeye_video_pkg::*;

logic [prom_w-1:0] prom_we;
logic              ready;
logic              game_reset;
logic [1:0]        rst_sr;

jtpopeye_cen u_cen(
    .clk        ( clk         ),
    .reset      ( reset       ),
    .pxl_cen    ( pxl_cen     ),
    .pxl2_cen   ( pxl2_cen    ),
    .sample     ( sample      )
);

jtpopeye_prom_we u_prom_we(
    .clk         ( clk         ),
    .reset       ( reset       ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_data  ( ioctl_data  ),
    .ioctl_wr    ( ioctl_wr    ),
    .prog_addr   ( prog_addr   ),
    .prog_data   ( prog_data   ),
    .prog_we     ( prog_we     ),
    .prom_we     ( prom_we     ),
    .encrypted   ( encrypted   )
);

jtpopeye_bram u_rom(
    .clk         ( clk                          ),
    .reset       ( reset                        ),
    .game_reset  ( game_reset                   ),
    .downloading ( downloading                  ),
    .prog_addr   ( prog_addr[main_rom_aw-1:0]   ),
    .prog_data   ( prog_data                    ),
    .prom_we     ( prom_we[we_main0 +: bank_n]  ),  // Bank bits only
    .main_cs     ( main_cs                      ),
    .main_addr   ( main_addr                    ),
    .main_data   ( main_data                    ),
    .main_ok     ( main_ok                      ),
    .ready       ( ready                        )
);

// Game logic leaves reset two cycles after the ROM is ready
always_ff @(posedge clk) begin
    if (reset || !ready) begin
        rst_sr <= 2'b00;
    end else begin
        rst_sr <= {rst_sr[0], 1'b1};
    end
end

assign game_reset = reset | ~rst_sr[1] | ~ready;

jtpopeye_vtiming u_vtiming(
    .clk         ( clk         ),
    .game_reset  ( game_reset  ),
    .pxl_cen     ( pxl_cen     ),
    .HB          ( HB          ),
    .VB          ( VB          ),
    .HS          ( HS          ),
    .VS          ( VS          )
);

jtpopeye_palette u_palette(
    .clk         ( clk                     ),
    .game_reset  ( game_reset              ),
    .pxl_cen     ( pxl_cen                 ),
    .prog_addr   ( prog_addr[pal_aw-1:0]   ),
    .prog_data   ( prog_data               ),
    .pal_we      ( prom_we[we_pal]         ),
    .pal_idx     ( pal_idx                 ),
    .HB          ( HB                      ),
    .VB          ( VB                      ),
    .red         ( red                     ),
    .green       ( green                   ),
    .blue        ( blue                    )
);

endmodule

/* src/jtpopeye_palette.sv */
`timescale 1ns/1ps

module jtpopeye_palette(
    input  logic                                     clk,
    input  logic                                     game_reset,
    input  logic                                     pxl_cen,
    input  logic [popeye_video_pkg::pal_aw-1:0]      prog_addr,
    input  logic [popeye_cfg_pkg::data_w-1:0]        prog_data,
    input  logic                                     pal_we,
    input  logic [popeye_video_pkg::pal_aw-1:0]      pal_idx,
    input  logic                                     HB,
    input  logic                                     VB,
    output logic [popeye_video_pkg::red_w-1:0]       red,
    output logic [popeye_video_pkg::green_w-1:0]     green,
    output logic [popeye_video_pkg::blue_w-1:0]      blue
);

import popeye_cfg_pkg::*;
import popeye_video_pkg::*;

logic [data_w-1:0] pal_rom [2**pal_aw];  // Colour PROM, RRRGGGBB
logic [pal_aw-1:0] idx_q;
logic              blank_q;

always_ff @(posedge clk) begin
    if (pal_we) pal_rom[prog_addr] <= prog_data;
end

// First stage, index taken on the pixel enable
always_ff @(posedge clk) begin
    if (pxl_cen) idx_q <= pal_idx;
end

// Second stage, PROM lookup one pixel later
always_ff @(posedge clk) begin
    if (game_reset) begin
        blank_q            <= 1'b1;
        {red, green, blue} <= '0;
    end else if (pxl_cen) begin
        blank_q            <= HB | VB;  // Travels with idx_q
        {red, green, blue} <= blank_q ? '0 : pal_rom[idx_q];
    end
end

endmodule

/* src/jtpopeye_prom_we.sv */
`timescale 1ns/1ps

module jtpopeye_prom_we(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     downloading,
    input  logic [popeye_cfg_pkg::dl_addr_w-1:0]     ioctl_addr,
    input  logic [popeye_cfg_pkg::data_w-1:0]        ioctl_data,
    input  logic                                     ioctl_wr,
    output logic [popeye_cfg_pkg::dl_addr_w-1:0]     prog_addr,
    output logic [popeye_cfg_pkg::data_w-1:0]        prog_data,
    output logic                                     prog_we,
    output logic [popeye_cfg_pkg::prom_w-1:0]        prom_we,
    output logic                                     encrypted
);

import popeye_cfg_pkg::*;

logic                 dl_wr;
logic [dl_addr_w-1:0] main_off;
logic [dl_addr_w-1:0] pal_off;
logic [prom_w-1:0]    region;

assign dl_wr = ioctl_wr & downloading;   // Writes outside a download are dropped

// Region decode from offsets into the download map
always_comb begin
    main_off = ioctl_addr - main_base;
    pal_off  = ioctl_addr - pal_base;
    region   = '0;
    if (main_off < main_size) begin
        region[we_main0 + main_off[main_rom_aw-1:bank_aw]] = 1'b1;
    end else if (pal_off < pal_size) begin
        region[we_pal] = 1'b1;
    end else if (ioctl_addr == crypt_addr) begin
        region[we_crypt] = 1'b1;
    end
    // Anything else strobes prog_we with no region bit
end

// Programming bus payload
always_ff @(posedge clk) begin
    if (dl_wr) begin
        prog_addr <= ioctl_addr;
        prog_data <= ioctl_data;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        prog_we   <= 1'b0;
        prom_we   <= '0;
        encrypted <= 1'b0;
    end else begin
        prog_we <= dl_wr;
        prom_we <= dl_wr ? region : '0;
        if (dl_wr && region[we_crypt]) begin
            encrypted <= ioctl_data[0];  // Kept until the next reset
        end
    end
end

// At most one memory is written per download byte
a_prom_we_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(prom_we)
) else $error("prom_we has more than one region selected");

endmodule

/* src/jtpopeye_vtiming.sv */
`timescale 1ns/1ps

module jtpopeye_vtiming(
    input  logic clk,
    input  logic game_reset,
    input  logic pxl_cen,
    output logic HB,    // Horizontal blanking
    output logic VB,    // Vertical blanking
    output logic HS,
    output logic VS
);

import popeye_video_pkg::*;

logic [h_cnt_w-1:0] hcnt;
logic [v_cnt_w-1:0] vcnt;
logic [h_cnt_w-1:0] h_nxt;
logic [v_cnt_w-1:0] v_nxt;

// Next position on the raster
always_comb begin
    h_nxt = hcnt + 1'd1;
    v_nxt = vcnt;
    if (hcnt == h_cnt_w'(h_total - 1)) begin
        h_nxt = '0;
        if (vcnt == v_cnt_w'(v_total - 1)) begin
            v_nxt = '0;
        end else begin
            v_nxt = vcnt + 1'd1;
        end
    end
end

// Flags come from the next count so they match the counters
always_ff @(posedge clk) begin
    if (game_reset) begin
        hcnt <= '0;
        vcnt <= '0;
        HB   <= 1'b0;
        VB   <= 1'b0;
        HS   <= 1'b0;
        VS   <= 1'b0;
    end else if (pxl_cen) begin
        hcnt <= h_nxt;
        vcnt <= v_nxt;
        HB   <= h_nxt >= h_cnt_w'(h_visible);
        VB   <= v_nxt >= v_cnt_w'(v_visible);
        HS   <= (h_nxt >= h_cnt_w'(hs_start)) && (h_nxt < h_cnt_w'(hs_end));
        VS   <= (v_nxt >= v_cnt_w'(vs_start)) && (v_nxt < v_cnt_w'(vs_end));
    end
end

// Sync pulse must sit inside the blanking interval
a_hs_in_hb: assert property (
    @(posedge clk) disable iff (game_reset)
    $rose(HS) |-> HB
) else $error("HS rose outside horizontal blanking");

endmodule

/* src/popeye_cfg_pkg.sv */
package popeye_cfg_pkg;

    // Download port
    localparam int dl_addr_w   = 22;
    localparam int data_w      = 8;

    // Main program ROM, 32 kB split in four 8 kB banks
    localparam int main_rom_aw = 15;
    localparam int bank_aw     = 13;
    localparam int bank_n      = 4;

    // Download memory map
    localparam logic [dl_addr_w-1:0] main_base  = 22'h00_0000;
    localparam logic [dl_addr_w-1:0] main_size  = 22'h00_8000;
    localparam logic [dl_addr_w-1:0] pal_base   = 22'h00_8000;
    localparam logic [dl_addr_w-1:0] pal_size   = 22'h00_0020;  // 32 colours
    localparam logic [dl_addr_w-1:0] crypt_addr = 22'h00_8020;  // Single flag byte

    // Region write enables
    localparam int prom_w   = 6;
    localparam int we_main0 = 0;    // Bits 0 to 3, one per bank
    localparam int we_pal   = 4;
    localparam int we_crypt = 5;

endpackage

/* src/popeye_video_pkg.sv */
package popeye_video_pkg;

    // Counter widths
    localparam int h_cnt_w   = 9;
    localparam int v_cnt_w   = 9;

    // Horizontal timing, in pixels
    localparam int h_total   = 320;
    localparam int h_visible = 256;
    localparam int hs_start  = 272;
    localparam int hs_end    = 296;

    // Vertical timing, in lines
    localparam int v_total   = 264;
    localparam int v_visible = 240;
    localparam int vs_start  = 248;
    localparam int vs_end    = 252;

    // Colour output
    localparam int red_w     = 3;
    localparam int green_w   = 3;
    localparam int blue_w    = 2;
    localparam int pal_aw    = 5;

endpackage

/* tests/tb_game.sv */
`timescale 1ns/1ps

module tb_game;

import popeye_cfg_pkg::*;
import popeye_video_pkg::*;

localparam int wait_max = 400000;   // More than one video frame of clocks
localparam int s_pxl2 = 0, s_pxl = 1, s_sample = 2, s_ok = 3;
localparam int s_hb = 4, s_vb = 5, s_hs = 6, s_vs = 7;

logic                   clk;
logic                   reset;
logic                   downloading;
logic [dl_addr_w-1:0]   ioctl_addr;
logic [data_w-1:0]      ioctl_data;
logic                   ioctl_wr;
logic                   main_cs;
logic [main_rom_aw-1:0] main_addr;
logic [pal_aw-1:0]      pal_idx;
logic                   pxl_cen, pxl2_cen, sample;
logic [dl_addr_w-1:0]   prog_addr;
logic [data_w-1:0]      prog_data;
logic                   prog_we;
logic                   encrypted;
logic [data_w-1:0]      main_data;
logic                   main_ok;
logic                   HB, VB, HS, VS;
logic [red_w-1:0]       red;
logic [green_w-1:0]     green;
logic [blue_w-1:0]      blue;

logic [31:0] golden [64];   // Per section a count word, then {address, byte} words
int          sec;           // First word of the current section
int          n_rec;
int          cnt;           // Clocks seen by the last wait
int          pulses;        // Pixel enables seen by the last wait
int          hb_pulses;
int          vb_pulses;
logic        exp_crypt;
logic [31:0] rec;

jtpopeye_game UUT(.*);

always #4 clk = ~clk;   // 8 ns period

task automatic stop_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: %s is %h, expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_byte(input string name, input logic [data_w-1:0] got,
                          input logic [data_w-1:0] exp);
    if (got !== exp) begin
        $display("Error: %s is %h, expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_addr(input string name, input logic [dl_addr_w-1:0] got,
                          input logic [dl_addr_w-1:0] exp);
    if (got !== exp) begin
        $display("Error: %s is %h, expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("Error: %s is %h, expected %h", name, got, exp);
        stop_run();
    end
endtask

// Colour byte is RRRGGGBB
task automatic check_rgb(input logic [red_w-1:0] r, input logic [green_w-1:0] g,
                         input logic [blue_w-1:0] b, input logic [data_w-1:0] exp);
    if (r !== exp[7:5] || g !== exp[4:2] || b !== exp[1:0]) begin
        $display("Error: red/green/blue is %h/%h/%h, expected %h/%h/%h",
                 r, g, b, exp[7:5], exp[4:2], exp[1:0]);
        stop_run();
    end
endtask

function automatic logic signal_of(input int sel);
    case (sel)
        s_pxl2:   return pxl2_cen;
        s_pxl:    return pxl_cen;
        s_sample: return sample;
        s_ok:     return main_ok;
        s_hb:     return HB;
        s_vb:     return VB;
        s_hs:     return HS;
        default:  return VS;
    endcase
endfunction

// Samples on falling edges until the selected signal changes to level
task automatic wait_edge(input int sel, input logic level, input int limit,
                         input string what);
    logic prev;
    logic now;
    logic seen;
    prev      = signal_of(sel);
    seen      = 1'b0;
    cnt       = 0;
    pulses    = 0;
    hb_pulses = 0;
    vb_pulses = 0;
    while (!seen) begin
        @(negedge clk);
        now  = signal_of(sel);
        seen = (now == level) && (prev != level);
        prev = now;
        cnt++;
        if (pxl_cen) pulses++;
        if (pxl_cen && HB) hb_pulses++;
        if (pxl_cen && VB) vb_pulses++;
        if (cnt > limit) begin
            $display("Timeout: %s", what);
            stop_run();
        end
    end
endtask

// One ioctl strobe, then a random idle gap
task automatic download_byte(input logic [dl_addr_w-1:0] addr,
                             input logic [data_w-1:0] data);
    int gap;
    gap        = int'($urandom % 4);
    ioctl_addr = addr;
    ioctl_data = data;
    ioctl_wr   = 1'b1;
    @(negedge clk);
    ioctl_wr = 1'b0;
    check_bit("prog_we", prog_we, downloading);   // One clock after the strobe
    check_bit("main_ok", main_ok, 1'b0);
    if (downloading) begin
        check_addr("prog_addr", prog_addr, addr);
        check_byte("prog_data", prog_data, data);
    end
    repeat (gap) begin
        @(negedge clk);
        check_bit("prog_we", prog_we, 1'b0);
    end
endtask

initial begin
    void'($urandom(32'h031a5b80));
    clk         = 1'b0;
    reset       = 1'b1;
    downloading = 1'b0;
    ioctl_addr  = '0;
    ioctl_data  = '0;
    ioctl_wr    = 1'b0;
    main_cs     = 1'b0;
    main_addr   = '0;
    pal_idx     = '0;
    $readmemh("tests/tb_game_golden.hex", golden);
    if ($isunknown(golden[0])) begin
        $display("The golden data file could not be read");
        stop_run();
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Everything still in its reset state
    check_bit("prog_we", prog_we, 1'b0);
    check_bit("encrypted", encrypted, 1'b0);
    check_bit("main_ok", main_ok, 1'b0);
    check_bit("HS", HS, 1'b0);
    check_bit("VS", VS, 1'b0);
    check_rgb(red, green, blue, 8'h00);
    check_bit("pxl2_cen", pxl2_cen, 1'b0);
    check_bit("pxl_cen", pxl_cen, 1'b0);
    check_bit("sample", sample, 1'b0);

    // Enable spacing from rising edge to rising edge
    wait_edge(s_pxl2, 1'b1, 32, "pxl2_cen never rose");
    wait_edge(s_pxl2, 1'b1, 32, "pxl2_cen did not rise again");
    check_count("pxl2_cen period", cnt, 2);
    wait_edge(s_pxl, 1'b1, 32, "pxl_cen never rose");
    wait_edge(s_pxl, 1'b1, 32, "pxl_cen did not rise again");
    check_count("pxl_cen period", cnt, 4);
    wait_edge(s_sample, 1'b1, 32, "sample never rose");
    wait_edge(s_sample, 1'b1, 32, "sample did not rise again");
    check_count("sample period", cnt, 16);

    download_byte(22'h00_0000, 8'hEE);   // Ignored without a running download

    main_cs     = 1'b1;   // Held read must not complete during the download
    downloading = 1'b1;
    exp_crypt   = 1'b0;
    n_rec       = golden[0];
    for (int i = 1; i <= n_rec; i++) begin
        rec = golden[i];
        download_byte(rec[8 +: dl_addr_w], rec[7:0]);
        if (rec[8 +: dl_addr_w] == crypt_addr) exp_crypt = rec[0];
        check_bit("encrypted", encrypted, exp_crypt);
    end
    downloading = 1'b0;
    wait_edge(s_ok, 1'b1, 16, "main_ok did not rise after the download");

    // Back-to-back reads each answered one clock later
    sec   = n_rec + 1;
    n_rec = golden[sec];
    for (int i = 0; i <= n_rec; i++) begin
        if (i > 0) begin
            rec = golden[sec + i];
            check_bit("main_ok", main_ok, 1'b1);
            check_byte("main_data", main_data, rec[7:0]);
        end
        if (i < n_rec) begin
            rec       = golden[sec + 1 + i];
            main_addr = rec[8 +: main_rom_aw];
        end
        @(negedge clk);
    end
    main_cs = 1'b0;
    @(negedge clk);
    check_bit("main_ok", main_ok, 1'b0);   // Follows main_cs one clock later

    // Single read started from an idle port
    rec       = golden[sec + 1];
    main_cs   = 1'b1;
    main_addr = rec[8 +: main_rom_aw];
    @(negedge clk);
    check_bit("main_ok", main_ok, 1'b1);
    check_byte("main_data", main_data, rec[7:0]);
    main_cs = 1'b0;

    wait_edge(s_hs, 1'b1, wait_max, "HS never rose");
    wait_edge(s_hs, 1'b1, wait_max, "HS did not rise again");
    check_count("pixels per HS period", pulses, h_total);
    check_count("HB pixels per line", hb_pulses, h_total - h_visible);
    wait_edge(s_vs, 1'b1, wait_max, "VS never rose");
    wait_edge(s_vs, 1'b1, wait_max, "VS did not rise again");
    check_count("pixels per VS period", pulses, h_total * v_total);
    check_count("VB pixels per frame", vb_pulses, h_total * (v_total - v_visible));

    sec   = sec + n_rec + 1;
    n_rec = golden[sec];
    for (int i = 1; i <= n_rec; i++) begin
        rec     = golden[sec + i];
        pal_idx = rec[8 +: pal_aw];
        wait_edge(s_vb, 1'b0, wait_max, "VB never fell");   // Top left of the screen
        repeat (4) wait_edge(s_pxl, 1'b1, 8, "pxl_cen stopped");
        check_rgb(red, green, blue, rec[7:0]);
        wait_edge(s_hb, 1'b1, wait_max, "HB never rose");
        repeat (4) wait_edge(s_pxl, 1'b1, 8, "pxl_cen stopped");
        check_rgb(red, green, blue, 8'h00);
    end

    $display("Everything OK");
    $finish;
end

endmodule

/* tests/tb_game_golden.hex */
// Three sections: download, main ROM reads, palette; each opens with its record count
// Record word: bits 31:8 address or palette index, bits 7:0 data or expected byte

// Download: address, byte
0000000E
00000012
000001A5
00000237
001FFFC3
0020005A
0041239E
006ABC47
007FFFE8
008000E4
0080051D
0080119B
00801FFF
00802001  // Encryption flag
0080400C  // Outside every region

// Main ROM reads: address, expected byte
00000008
006ABC47
00000012
007FFFE8
000001A5
0020005A
001FFFC3
0041239E
00000237

// Palette: index, expected RRRGGGBB byte
00000004
000000E4
0000051D
0000119B
00001FFF
